// File: tap_pkg.sv
package tap_pkg;

    // instruction register
    localparam int IR_LEN = 4;
    typedef logic [IR_LEN-1:0] ir_t;

    localparam ir_t IR_IDCODE = 4'b0001;
    localparam ir_t IR_RTDR0  = 4'b1000;
    localparam ir_t IR_RTDR1  = 4'b1001;
    localparam ir_t IR_RTDR2  = 4'b1010;
    localparam ir_t IR_BYPASS = 4'b1111;

    // loaded at Capture-IR, low two bits fixed at 01 per 1149.1
    localparam ir_t IR_CAPTURE_VALUE = 4'b0101;

    // remote test data registers
    localparam int RTDR_COUNT = 3;
    localparam int RTDR_LEN   = 16;
    typedef logic [RTDR_LEN-1:0] rtdr_data_t;

    // identification register, bit 0 must read as 1
    localparam int IDCODE_LEN = 32;
    typedef logic [IDCODE_LEN-1:0] idcode_t;
    localparam idcode_t IDCODE_VALUE = 32'h1A5C_E0B3;

    // controller states, standard 1149.1 encoding
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'hF,
        RUN_TEST_IDLE    = 4'hC,
        SELECT_DR_SCAN   = 4'h7,
        CAPTURE_DR       = 4'h6,
        SHIFT_DR         = 4'h2,
        EXIT1_DR         = 4'h1,
        PAUSE_DR         = 4'h3,
        EXIT2_DR         = 4'h0,
        UPDATE_DR        = 4'h5,
        SELECT_IR_SCAN   = 4'h4,
        CAPTURE_IR       = 4'hE,
        SHIFT_IR         = 4'hA,
        EXIT1_IR         = 4'h9,
        PAUSE_IR         = 4'hB,
        EXIT2_IR         = 4'h8,
        UPDATE_IR        = 4'hD
    } tap_state_t;

endpackage

// File: rtdr_if.sv
`timescale 1ns/1ns

interface rtdr_if;

    logic irdec;
    logic capture;
    logic shift;
    logic update;
    logic tdi;
    logic tdo;

    modport tap (
        output irdec,
        output capture,
        output shift,
        output update,
        output tdi,
        input  tdo
    );

    modport rtdr (
        input  irdec,
        input  capture,
        input  shift,
        input  update,
        input  tdi,
        output tdo
    );

endinterface

// File: tap_fsm.sv
`timescale 1ns/1ns

module tap_fsm import tap_pkg::*; (
    input  logic       tck,
    input  logic       reset,
    input  logic       tms,
    output tap_state_t state,
    output logic       capture_dr,
    output logic       shift_dr,
    output logic       update_dr,
    output logic       capture_ir,
    output logic       shift_ir,
    output logic       update_ir,
    output logic       test_reset
);

    tap_state_t next_state;

    always_ff @(posedge tck) begin
        if (reset) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= next_state;
        end
    end

    // 1149.1 transition table, tms only
    always_comb begin
        next_state = state;
        case (state)
            TEST_LOGIC_RESET: next_state = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   next_state = tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       next_state = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         next_state = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         next_state = tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         next_state = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         next_state = tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   next_state = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       next_state = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         next_state = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         next_state = tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         next_state = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         next_state = tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        next_state = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          next_state = TEST_LOGIC_RESET;
        endcase
    end

    // strobes follow the state, the action lands on the edge leaving it
    always_comb begin
        capture_dr = (state == CAPTURE_DR);
        shift_dr   = (state == SHIFT_DR);
        update_dr  = (state == UPDATE_DR);
        capture_ir = (state == CAPTURE_IR);
        shift_ir   = (state == SHIFT_IR);
        update_ir  = (state == UPDATE_IR);
        test_reset = (state == TEST_LOGIC_RESET);
    end

endmodule

// File: tap_datapath.sv
`timescale 1ns/1ns

module tap_datapath import tap_pkg::*; (
    input  logic   tck,
    input  logic   reset,
    input  logic   tdi,
    input  logic   capture_dr,
    input  logic   shift_dr,
    input  logic   update_dr,
    input  logic   capture_ir,
    input  logic   shift_ir,
    input  logic   update_ir,
    input  logic   test_reset,
    rtdr_if.tap    rtdr [RTDR_COUNT],
    output logic   tdo
);

    ir_t                   ir_shift;
    ir_t                   ir_update;
    logic                  sel_idcode;
    logic                  sel_bypass;
    logic [RTDR_COUNT-1:0] sel_rtdr;
    logic                  bypass_reg;
    idcode_t               idcode_shift;
    logic [RTDR_COUNT-1:0] rtdr_tdo;

    // ir shift stage, lsb first
    always_ff @(posedge tck) begin
        if (capture_ir) begin
            ir_shift <= IR_CAPTURE_VALUE;
        end else if (shift_ir) begin
            ir_shift <= {tdi, ir_shift[IR_LEN-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (reset || test_reset) begin
            ir_update <= IR_IDCODE;
        end else if (update_ir) begin
            ir_update <= ir_shift;
        end
    end

    // unassigned codes fall through to bypass
    always_comb begin
        sel_idcode = 1'b0;
        sel_bypass = 1'b0;
        sel_rtdr   = '0;
        case (ir_update)
            IR_IDCODE: sel_idcode  = 1'b1;
            IR_RTDR0:  sel_rtdr[0] = 1'b1;
            IR_RTDR1:  sel_rtdr[1] = 1'b1;
            IR_RTDR2:  sel_rtdr[2] = 1'b1;
            default:   sel_bypass  = 1'b1;
        endcase
    end

    always_ff @(posedge tck) begin
        if (capture_dr && sel_bypass) begin
            bypass_reg <= 1'b0;
        end else if (shift_dr && sel_bypass) begin
            bypass_reg <= tdi;
        end
    end

    always_ff @(posedge tck) begin
        if (capture_dr && sel_idcode) begin
            idcode_shift <= IDCODE_VALUE;
        end else if (shift_dr && sel_idcode) begin
            idcode_shift <= {tdi, idcode_shift[IDCODE_LEN-1:1]};
        end
    end

    for (genvar i = 0; i < RTDR_COUNT; i++) begin : g_rtdr
        assign rtdr[i].irdec   = sel_rtdr[i];
        assign rtdr[i].capture = capture_dr & sel_rtdr[i];
        assign rtdr[i].shift   = shift_dr & sel_rtdr[i];
        assign rtdr[i].update  = update_dr & sel_rtdr[i];
        assign rtdr[i].tdi     = tdi;
        assign rtdr_tdo[i]     = rtdr[i].tdo;
    end

    always_comb begin
        tdo = 1'b0;
        if (shift_ir) begin
            tdo = ir_shift[0];
        end else if (shift_dr) begin
            if (sel_idcode) begin
                tdo = idcode_shift[0];
            end else if (sel_bypass) begin
                tdo = bypass_reg;
            end else begin
                tdo = |(sel_rtdr & rtdr_tdo);
            end
        end
    end

endmodule

// File: rtdr_reg.sv
`timescale 1ns/1ns

module rtdr_reg import tap_pkg::*; (
    input  logic       tck,
    input  logic       reset,
    rtdr_if.rtdr       rtdr,
    input  rtdr_data_t status,
    output rtdr_data_t ctrl
);

    rtdr_data_t shift_q;

    // status in at capture, tdi enters at the msb
    always_ff @(posedge tck) begin
        if (rtdr.capture) begin
            shift_q <= status;
        end else if (rtdr.shift) begin
            shift_q <= {rtdr.tdi, shift_q[RTDR_LEN-1:1]};
        end
    end

    // control word only moves on update
    always_ff @(posedge tck) begin
        if (reset) begin
            ctrl <= '0;
        end else if (rtdr.update) begin
            ctrl <= shift_q;
        end
    end

    assign rtdr.tdo = shift_q[0];

endmodule

// File: tap_rtdr_top.sv
`timescale 1ns/1ns

module tap_rtdr_top import tap_pkg::*; (
    input  logic       tck,
    input  logic       reset,
    input  logic       tms,
    input  logic       tdi,
    output logic       tdo,
    input  rtdr_data_t status0,
    input  rtdr_data_t status1,
    input  rtdr_data_t status2,
    output rtdr_data_t ctrl0,
    output rtdr_data_t ctrl1,
    output rtdr_data_t ctrl2
);

    tap_state_t tap_state;
    logic       capture_dr;
    logic       shift_dr;
    logic       update_dr;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;
    logic       test_reset;

    rtdr_if rtdr_bus [RTDR_COUNT] ();

    tap_fsm u_fsm (
        .tck        (tck),
        .reset      (reset),
        .tms        (tms),
        .state      (tap_state),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .test_reset (test_reset)
    );

    tap_datapath u_datapath (
        .tck        (tck),
        .reset      (reset),
        .tdi        (tdi),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .test_reset (test_reset),
        .rtdr       (rtdr_bus),
        .tdo        (tdo)
    );

    rtdr_reg u_rtdr0 (
        .tck    (tck),
        .reset  (reset),
        .rtdr   (rtdr_bus[0]),
        .status (status0),
        .ctrl   (ctrl0)
    );

    rtdr_reg u_rtdr1 (
        .tck    (tck),
        .reset  (reset),
        .rtdr   (rtdr_bus[1]),
        .status (status1),
        .ctrl   (ctrl1)
    );

    rtdr_reg u_rtdr2 (
        .tck    (tck),
        .reset  (reset),
        .rtdr   (rtdr_bus[2]),
        .status (status2),
        .ctrl   (ctrl2)
    );

endmodule

// File: tap_rtdr_checker.sv
`timescale 1ns/1ns

module tap_rtdr_checker import tap_pkg::*; (
    input logic                  tck,
    input logic                  reset,
    input ir_t                   ir_update,
    input logic [RTDR_COUNT-1:0] irdec,
    input logic [RTDR_COUNT-1:0] dr_strobe
);

    // only one remote register may be selected at a time
    assert property (@(posedge tck) disable iff (reset) $onehot0(irdec))
        else $error("more than one rtdr irdec line high: %b", irdec);

    // capture, shift and update stay gated by the decode
    assert property (@(posedge tck) disable iff (reset) (dr_strobe & ~irdec) == '0)
        else $error("dr strobe reached an rtdr without irdec: strobe %b irdec %b",
                    dr_strobe, irdec);

    assert property (@(posedge tck) reset |=> (ir_update == IR_IDCODE))
        else $error("ir is %h one cycle after reset", ir_update);

endmodule

bind tap_datapath tap_rtdr_checker u_checker (
    .tck       (tck),
    .reset     (reset),
    .ir_update (ir_update),
    .irdec     ({rtdr[2].irdec, rtdr[1].irdec, rtdr[0].irdec}),
    .dr_strobe ({rtdr[2].capture | rtdr[2].shift | rtdr[2].update,
                 rtdr[1].capture | rtdr[1].shift | rtdr[1].update,
                 rtdr[0].capture | rtdr[0].shift | rtdr[0].update})
);

// File: tb_tap_rtdr.sv
`timescale 1ns/1ns

module tb_tap_rtdr import tap_pkg::*; ();

    logic       tck;
    logic       reset;
    logic       tms;
    logic       tdi;
    logic       tdo;
    rtdr_data_t status_in [RTDR_COUNT];
    rtdr_data_t ctrl_out [RTDR_COUNT];
    rtdr_data_t exp_ctrl [RTDR_COUNT];
    integer     seed;
    int         checks;
    int         errors;

    tap_rtdr_top uut (
        .tck     (tck),
        .reset   (reset),
        .tms     (tms),
        .tdi     (tdi),
        .tdo     (tdo),
        .status0 (status_in[0]),
        .status1 (status_in[1]),
        .status2 (status_in[2]),
        .ctrl0   (ctrl_out[0]),
        .ctrl1   (ctrl_out[1]),
        .ctrl2   (ctrl_out[2])
    );

    always #10 tck = ~tck;

    task automatic end_run;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic check_ir(input string name, input ir_t exp, input ir_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_rtdr(input string name, input rtdr_data_t exp, input rtdr_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_idcode(input string name, input idcode_t exp, input idcode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_all_ctrl;
        check_rtdr("ctrl0", exp_ctrl[0], ctrl_out[0]);
        check_rtdr("ctrl1", exp_ctrl[1], ctrl_out[1]);
        check_rtdr("ctrl2", exp_ctrl[2], ctrl_out[2]);
    endtask

    // one tck cycle, entered and left 2 ns after a rising edge
    task automatic tick(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms = tms_v;
        tdi = tdi_v;
        @(negedge tck);
        tdo_v = tdo;
        @(posedge tck);
        #2;
    endtask

    task automatic wait_state(input tap_state_t target, input logic tms_v, input int limit);
        int   n;
        logic b;
        n = 0;
        while (uut.tap_state != target && n < limit) begin
            tick(tms_v, 1'b0, b);
            n++;
        end
        if (uut.tap_state != target) begin
            errors++;
            $display("timeout: controller did not reach %s within %0d cycles",
                     target.name(), limit);
            end_run();
        end
    endtask

    task automatic goto_reset;
        wait_state(TEST_LOGIC_RESET, 1'b1, 5);
    endtask

    task automatic goto_idle;
        wait_state(RUN_TEST_IDLE, 1'b0, 4);
    endtask

    // starts and ends in Run-Test/Idle
    task automatic scan_ir(input ir_t ir_in, output ir_t ir_out);
        logic b;
        ir_out = '0;
        tick(1'b1, 1'b0, b);
        tick(1'b1, 1'b0, b);
        tick(1'b0, 1'b0, b);
        tick(1'b0, 1'b0, b);
        for (int i = 0; i < IR_LEN; i++) begin
            tick(i == IR_LEN - 1, ir_in[i], b);
            ir_out[i] = b;
        end
        tick(1'b1, 1'b0, b);
        tick(1'b0, 1'b0, b);
    endtask

    task automatic scan_dr(input idcode_t data_in, input int nbits, output idcode_t data_out);
        logic b;
        data_out = '0;
        tick(1'b1, 1'b0, b);
        tick(1'b0, 1'b0, b);
        tick(1'b0, 1'b0, b);
        for (int i = 0; i < nbits; i++) begin
            tick(i == nbits - 1, data_in[i], b);
            data_out[i] = b;
        end
        tick(1'b1, 1'b0, b);
        // ctrl moves on the edge leaving Update-DR
        tick(1'b0, 1'b0, b);
    endtask

    task automatic check_bypass_path;
        logic [7:0] d;
        idcode_t    out;
        d = $random(seed);
        scan_dr({24'h0, d}, 9, out);
        check_bit("bypass tdo[0]", 1'b0, out[0]);
        for (int i = 1; i < 9; i++) begin
            check_bit($sformatf("bypass tdo[%0d]", i), d[i-1], out[i]);
        end
    endtask

    task automatic test_idcode_after_reset;
        idcode_t out;
        check_ir("ir after reset", IR_IDCODE, uut.u_datapath.ir_update);
        check_all_ctrl();
        goto_idle();
        scan_dr('0, IDCODE_LEN, out);
        check_idcode("idcode", IDCODE_VALUE, out);
    endtask

    task automatic test_bypass;
        ir_t cap;
        scan_ir(IR_BYPASS, cap);
        check_ir("ir capture", IR_CAPTURE_VALUE, cap);
        check_bypass_path();
        check_all_ctrl();
    endtask

    task automatic test_rtdr_write(input int k);
        ir_t        codes [RTDR_COUNT];
        ir_t        cap;
        rtdr_data_t word;
        idcode_t    out;
        codes = '{IR_RTDR0, IR_RTDR1, IR_RTDR2};
        status_in[k] = $random(seed);
        word = $random(seed);
        scan_ir(codes[k], cap);
        check_ir("ir capture", IR_CAPTURE_VALUE, cap);
        scan_dr({16'h0, word}, RTDR_LEN, out);
        check_rtdr($sformatf("status%0d on tdo", k), status_in[k], out[RTDR_LEN-1:0]);
        exp_ctrl[k] = word;
        check_all_ctrl();
    endtask

    task automatic test_unassigned_ir;
        ir_t cap;
        scan_ir(4'b0011, cap);
        check_ir("ir capture", IR_CAPTURE_VALUE, cap);
        check_bypass_path();
        check_all_ctrl();
    endtask

    task automatic test_reset_from_shift;
        logic    b;
        idcode_t out;
        tick(1'b1, 1'b0, b);
        tick(1'b0, 1'b0, b);
        tick(1'b0, 1'b0, b);
        repeat (3) tick(1'b0, 1'b1, b);
        goto_reset();
        // the ir reload lands on the edge leaving Test-Logic-Reset
        goto_idle();
        check_ir("ir after test-logic-reset", IR_IDCODE, uut.u_datapath.ir_update);
        scan_dr('0, IDCODE_LEN, out);
        check_idcode("idcode after tms reset", IDCODE_VALUE, out);
        check_all_ctrl();
    endtask

    initial begin
        seed = 70945;
        checks = 0;
        errors = 0;
        tck = 1'b0;
        reset = 1'b1;
        tms = 1'b1;
        tdi = 1'b0;
        for (int i = 0; i < RTDR_COUNT; i++) begin
            status_in[i] = $random(seed);
            exp_ctrl[i] = '0;
        end
        repeat (5) @(posedge tck);
        #2;
        reset = 1'b0;
        test_idcode_after_reset();
        test_bypass();
        for (int k = 0; k < RTDR_COUNT; k++) begin
            test_rtdr_write(k);
        end
        test_unassigned_ir();
        test_reset_from_shift();
        end_run();
    end

endmodule

// File: all.f
tap_pkg.sv
rtdr_if.sv
tap_fsm.sv
tap_datapath.sv
rtdr_reg.sv
tap_rtdr_top.sv
tap_rtdr_checker.sv
tb_tap_rtdr.sv
